//--- verilog/fp_format_pkg.sv
/*
  Format select and field layout for the divide/square-root result packer.
  Only double, single and half are supported. Denormal results are not
  produced, and every NaN result is the canonical quiet NaN of its format.
*/

package fp_format_pkg;

  // Format select carried with every item
  typedef enum logic [1:0] {
    FMT_DOUBLE = 2'b00,
    FMT_SINGLE = 2'b01,
    FMT_HALF   = 2'b10
  } fp_fmt_t;

  // Exponent field widths
  localparam int EXP_W_D = 11;
  localparam int EXP_W_S = 8;
  localparam int EXP_W_H = 5;

  // Stored fraction widths, hidden bit excluded
  localparam int FRAC_W_D = 52;
  localparam int FRAC_W_S = 23;
  localparam int FRAC_W_H = 10;

  // Packed result, always 64 bits wide
  localparam int RESULT_W = 64;

  // Rounded fraction from the divider, two integer bits on top
  localparam int IN_FRAC_W = 55;

  // Exponent before the late adjust, with guard bits for over/underflow
  localparam int EXPNT_W = 13;

  // Fraction after normalization, sized for double
  localparam int NORM_FRAC_W = 52;

  // Number of ones placed above a narrower format (NaN boxing)
  localparam int BOX_W_S = RESULT_W - 1 - EXP_W_S - FRAC_W_S;
  localparam int BOX_W_H = RESULT_W - 1 - EXP_W_H - FRAC_W_H;

  // Exponent of the largest finite number, widest format.
  // Its low bits give the narrower formats as well: 8'hfe, 5'h1e
  localparam logic [EXP_W_D-1:0] EXP_LFN_PAT = {{(EXP_W_D - 1){1'b1}}, 1'b0};

  // Exponent of infinity and NaN
  localparam logic [EXP_W_D-1:0] EXP_ONES_PAT = {EXP_W_D{1'b1}};

  // Canonical quiet NaN fraction, top bit set only.
  // Taking the top bits keeps it right for every format
  localparam logic [NORM_FRAC_W-1:0] QNAN_FRAC_PAT = {1'b1, {(NORM_FRAC_W - 1){1'b0}}};

  // Fraction of the largest finite number
  localparam logic [NORM_FRAC_W-1:0] LFN_FRAC_PAT = {NORM_FRAC_W{1'b1}};

endpackage

//--- verilog/pack_pipe_pkg.sv
/*
  Records passed between the packer stages.
  Flag order follows the usual IEEE exception vector: nv, dz, of, uf, nx,
  with nv in the most significant bit.
*/

package pack_pipe_pkg;

  localparam int FLAG_W = 5;

  // Exception flags, nv on top
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } pack_flags_t;

  // Result class, exactly one bit set
  typedef enum logic [4:0] {
    CLS_ZERO = 5'b10000,
    CLS_QNAN = 5'b01000,
    CLS_INF  = 5'b00100,
    CLS_LFN  = 5'b00010,
    CLS_NORM = 5'b00001
  } rslt_class_t;

  // Producer output, settled class and corrected flags
  typedef struct packed {
    fp_format_pkg::fp_fmt_t                      fmt;
    logic                                        sign;
    rslt_class_t                                 cls;
    logic [fp_format_pkg::EXPNT_W-1:0]           expnt;
    logic [fp_format_pkg::NORM_FRAC_W-1:0]       frac;
    pack_flags_t                                 flags;
  } pack_req_t;

  // Final packed result
  typedef struct packed {
    logic [fp_format_pkg::RESULT_W-1:0] result;
    pack_flags_t                        flags;
  } pack_rslt_t;

endpackage

//--- verilog/fdsu_expnt_adjust.sv
/*
  Combinational producer stage. req and ack pass straight through, so the
  data must be held by upstream while req is high.
  Class hints need not be one-hot: zero wins over NaN, then inf, then lfn.
*/
`timescale 1ns/1ps

module fdsu_expnt_adjust (
  input  logic                                 req,
  output logic                                 req_o,
  input  logic                                 ack_in,
  output logic                                 ack,
  input  fp_format_pkg::fp_fmt_t               fmt,
  input  logic                                 sign,
  input  logic [fp_format_pkg::IN_FRAC_W-1:0]  frac,
  input  logic [fp_format_pkg::EXPNT_W-1:0]    expnt,
  input  logic                                 nv,
  input  logic                                 dz,
  input  logic                                 of,
  input  logic                                 uf,
  input  logic                                 nx,
  input  logic                                 potnt_of,
  input  logic                                 potnt_uf,
  input  logic                                 of_rm_lfn,
  input  logic                                 result_zero,
  input  logic                                 result_qnan,
  input  logic                                 result_inf,
  input  logic                                 result_lfn,
  input  logic                                 result_nor,
  output pack_pipe_pkg::pack_req_t             data
);

  import fp_format_pkg::*;
  import pack_pipe_pkg::*;

  logic [1:0] top_pair;
  logic       of_plus;
  logic       uf_plus;
  logic       cls_inf;
  logic       cls_lfn;

  assign req_o = req;
  assign ack   = ack_in;

  // Integer bits of the rounded fraction
  assign top_pair = frac[IN_FRAC_W-1 -: 2];

  // Late over/underflow after the final normalize step
  assign of_plus = potnt_of && (|top_pair) && result_nor;
  assign uf_plus = potnt_uf && (~|top_pair) && result_nor;

  assign cls_lfn = (of_plus && of_rm_lfn) || result_lfn;
  assign cls_inf = (of_plus && !of_rm_lfn) || result_inf;

  always_comb
  begin
    data.fmt  = fmt;
    data.sign = sign;

    // Exponent and fraction follow the position of the leading one
    unique casez (top_pair)
      2'b00:
      begin
        data.expnt = expnt - EXPNT_W'(1);
        data.frac  = frac[NORM_FRAC_W-1:0];
      end
      2'b01:
      begin
        data.expnt = expnt;
        data.frac  = frac[NORM_FRAC_W:1];
      end
      default:
      begin
        data.expnt = expnt + EXPNT_W'(1);
        data.frac  = frac[NORM_FRAC_W+1:2];
      end
    endcase

    // Fixed priority over the class hints
    if (result_zero)
      data.cls = CLS_ZERO;
    else if (result_qnan)
      data.cls = CLS_QNAN;
    else if (cls_inf)
      data.cls = CLS_INF;
    else if (cls_lfn)
      data.cls = CLS_LFN;
    else
      data.cls = CLS_NORM;

    data.flags.nv = nv;
    data.flags.dz = dz;
    data.flags.of = of || of_plus;
    // Underflow is only signalled when the result is also inexact
    data.flags.uf = (uf || uf_plus) && nx;
    data.flags.nx = nx || of || of_plus;
  end

endmodule

//--- verilog/hs4_buffer.sv
/*
  One-entry buffer with four-phase req/ack on both sides.
  in_ack and out_req are registered. A new item is taken only when the
  buffer is empty and the previous input handshake has fully returned to zero.
*/
`timescale 1ns/1ps

module hs4_buffer #(
  parameter type payload_t = logic
) (
  input  logic     forever_cpuclk,
  input  logic     reset,
  input  logic     in_req,
  output logic     in_ack,
  input  payload_t in_data,
  output logic     out_req,
  input  logic     out_ack,
  output payload_t out_data
);

  logic full;
  // Output side saw ack and now waits for it to fall
  logic out_done;
  logic take;

  assign take = in_req && !full && !in_ack;

  always_ff @(posedge forever_cpuclk)
  begin
    if (reset)
    begin
      full     <= 1'b0;
      in_ack   <= 1'b0;
      out_req  <= 1'b0;
      out_done <= 1'b0;
    end
    else
    begin
      // Input side
      if (take)
        in_ack <= 1'b1;
      else if (in_ack && !in_req)
        in_ack <= 1'b0;

      // Output side
      if (take)
      begin
        full    <= 1'b1;
        out_req <= 1'b1;
      end
      else if (out_req && out_ack)
      begin
        out_req  <= 1'b0;
        out_done <= 1'b1;
      end
      else if (out_done && !out_ack)
      begin
        out_done <= 1'b0;
        full     <= 1'b0;
      end
    end
  end

  // Payload register
  always_ff @(posedge forever_cpuclk)
  begin
    if (take)
      out_data <= in_data;
  end

endmodule

//--- verilog/fdsu_result_pack.sv
/*
  Combinational consumer stage that forms the 64-bit result.
  Single and half results are NaN-boxed with ones in the upper bits.
  Any NaN comes out as the canonical quiet NaN with a positive sign.
*/
`timescale 1ns/1ps

module fdsu_result_pack (
  input  logic                      req,
  output logic                      req_o,
  input  logic                      ack_in,
  output logic                      ack,
  input  pack_pipe_pkg::pack_req_t  data,
  output pack_pipe_pkg::pack_rslt_t rslt
);

  import fp_format_pkg::*;
  import pack_pipe_pkg::*;

  // Fields for the widest format; narrower ones take a slice
  logic                   sign_sel;
  logic [EXP_W_D-1:0]     exp_sel;
  logic [NORM_FRAC_W-1:0] frac_sel;

  logic [RESULT_W-1:0]    rslt_d;
  logic [RESULT_W-1:0]    rslt_s;
  logic [RESULT_W-1:0]    rslt_h;

  assign req_o = req;
  assign ack   = ack_in;

  always_comb
  begin
    // Normal number unless a special class overrides
    sign_sel = data.sign;
    exp_sel  = data.expnt[EXP_W_D-1:0];
    frac_sel = data.frac;

    // Payload is only meaningful while req is high
    case (data.cls)
      CLS_ZERO:
      begin
        exp_sel  = '0;
        frac_sel = '0;
      end
      CLS_QNAN:
      begin
        sign_sel = 1'b0;
        exp_sel  = EXP_ONES_PAT;
        frac_sel = QNAN_FRAC_PAT;
      end
      CLS_INF:
      begin
        exp_sel  = EXP_ONES_PAT;
        frac_sel = '0;
      end
      CLS_LFN:
      begin
        exp_sel  = EXP_LFN_PAT;
        frac_sel = LFN_FRAC_PAT;
      end
      CLS_NORM:
      begin
        exp_sel  = data.expnt[EXP_W_D-1:0];
        frac_sel = data.frac;
      end
      default:
      begin
        exp_sel  = data.expnt[EXP_W_D-1:0];
        frac_sel = data.frac;
      end
    endcase
  end

  // Low exponent bits and top fraction bits per format
  assign rslt_d = {sign_sel,
                   exp_sel[EXP_W_D-1:0],
                   frac_sel[NORM_FRAC_W-1 -: FRAC_W_D]};

  assign rslt_s = {{BOX_W_S{1'b1}},
                   sign_sel,
                   exp_sel[EXP_W_S-1:0],
                   frac_sel[NORM_FRAC_W-1 -: FRAC_W_S]};

  assign rslt_h = {{BOX_W_H{1'b1}},
                   sign_sel,
                   exp_sel[EXP_W_H-1:0],
                   frac_sel[NORM_FRAC_W-1 -: FRAC_W_H]};

  always_comb
  begin
    case (data.fmt)
      FMT_SINGLE: rslt.result = rslt_s;
      FMT_HALF:   rslt.result = rslt_h;
      // Double, and the unused select code
      default:    rslt.result = rslt_d;
    endcase
    rslt.flags = data.flags;
  end

endmodule

//--- verilog/fdsu_pack_top.sv
/*
  Result packer: producer, buffer, consumer, buffer.
  Four-phase req/ack on both sides. At most two items are held inside.
  Inputs must stay stable while in_req is high.
*/
`timescale 1ns/1ps

module fdsu_pack_top (
  input  logic                                  forever_cpuclk,
  input  logic                                  reset,
  input  logic                                  in_req,
  output logic                                  in_ack,
  input  fp_format_pkg::fp_fmt_t                fmt,
  input  logic                                  sign,
  input  logic [fp_format_pkg::IN_FRAC_W-1:0]   frac,
  input  logic [fp_format_pkg::EXPNT_W-1:0]     expnt,
  input  logic                                  nv,
  input  logic                                  dz,
  input  logic                                  of,
  input  logic                                  uf,
  input  logic                                  nx,
  input  logic                                  potnt_of,
  input  logic                                  potnt_uf,
  input  logic                                  of_rm_lfn,
  input  logic                                  result_zero,
  input  logic                                  result_qnan,
  input  logic                                  result_inf,
  input  logic                                  result_lfn,
  input  logic                                  result_nor,
  output logic                                  out_req,
  input  logic                                  out_ack,
  output logic [fp_format_pkg::RESULT_W-1:0]    result,
  output logic [pack_pipe_pkg::FLAG_W-1:0]      expt
);

  // Producer to buffer A
  logic                      adj_req;
  logic                      buf_a_ack;
  pack_pipe_pkg::pack_req_t  adj_data;

  // Buffer A to consumer
  logic                      buf_a_req;
  logic                      pack_ack;
  pack_pipe_pkg::pack_req_t  buf_a_data;

  // Consumer to buffer B
  logic                      pack_req;
  logic                      buf_b_ack;
  pack_pipe_pkg::pack_rslt_t pack_rslt;
  pack_pipe_pkg::pack_rslt_t buf_b_data;

  fdsu_expnt_adjust fdsu_expnt_adjust_i (
    .req         (in_req),
    .req_o       (adj_req),
    .ack_in      (buf_a_ack),
    .ack         (in_ack),
    .fmt         (fmt),
    .sign        (sign),
    .frac        (frac),
    .expnt       (expnt),
    .nv          (nv),
    .dz          (dz),
    .of          (of),
    .uf          (uf),
    .nx          (nx),
    .potnt_of    (potnt_of),
    .potnt_uf    (potnt_uf),
    .of_rm_lfn   (of_rm_lfn),
    .result_zero (result_zero),
    .result_qnan (result_qnan),
    .result_inf  (result_inf),
    .result_lfn  (result_lfn),
    .result_nor  (result_nor),
    .data        (adj_data)
  );

  hs4_buffer #(
    .payload_t (pack_pipe_pkg::pack_req_t)
  ) hs4_buffer_a_i (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .in_req         (adj_req),
    .in_ack         (buf_a_ack),
    .in_data        (adj_data),
    .out_req        (buf_a_req),
    .out_ack        (pack_ack),
    .out_data       (buf_a_data)
  );

  fdsu_result_pack fdsu_result_pack_i (
    .req    (buf_a_req),
    .req_o  (pack_req),
    .ack_in (buf_b_ack),
    .ack    (pack_ack),
    .data   (buf_a_data),
    .rslt   (pack_rslt)
  );

  hs4_buffer #(
    .payload_t (pack_pipe_pkg::pack_rslt_t)
  ) hs4_buffer_b_i (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .in_req         (pack_req),
    .in_ack         (buf_b_ack),
    .in_data        (pack_rslt),
    .out_req        (out_req),
    .out_ack        (out_ack),
    .out_data       (buf_b_data)
  );

  assign result = buf_b_data.result;
  assign expt   = buf_b_data.flags;

endmodule

//--- verification/fdsu_pack_sva.sv
/*
  Handshake checks bound into the result packer top level.
  The latency check only applies when both buffers start out empty.
  fail_cnt counts assertion failures for the testbench summary.
*/
`timescale 1ns/1ps

module fdsu_pack_sva (
  input logic                               forever_cpuclk,
  input logic                               reset,
  input logic                               in_req,
  input logic                               in_ack,
  input logic                               out_req,
  input logic                               out_ack,
  input logic [fp_format_pkg::RESULT_W-1:0] result,
  input logic [pack_pipe_pkg::FLAG_W-1:0]   expt,
  input logic                               a_full,
  input logic                               b_full,
  input logic                               b_in_ack
);

  int   fail_cnt = 0;
  logic accept;
  logic b_idle;

  // Buffer A takes the item at this edge
  assign accept = in_req && !in_ack && !a_full;
  assign b_idle = !b_full && !b_in_ack;

  reset_idle: assert property (@(posedge forever_cpuclk) reset |=> !in_ack && !out_req)
    else begin fail_cnt++; $error("in_ack or out_req high after reset"); end

  req_held: assert property (@(posedge forever_cpuclk) disable iff (reset)
    out_req && !out_ack |=> out_req)
    else begin fail_cnt++; $error("out_req dropped before out_ack"); end

  data_stable: assert property (@(posedge forever_cpuclk) disable iff (reset)
    out_req |=> !out_req || ($stable(result) && $stable(expt)))
    else begin fail_cnt++; $error("result or expt changed while out_req high"); end

  ack_latency: assert property (@(posedge forever_cpuclk) disable iff (reset)
    accept |=> in_ack)
    else begin fail_cnt++; $error("in_ack did not rise one cycle after in_req"); end

  out_latency: assert property (@(posedge forever_cpuclk) disable iff (reset)
    accept && b_idle |-> ##2 $rose(out_req))
    else begin fail_cnt++; $error("out_req did not rise two cycles after in_req"); end

endmodule

bind fdsu_pack_top fdsu_pack_sva fdsu_pack_sva_i (
  .forever_cpuclk (forever_cpuclk),
  .reset          (reset),
  .in_req         (in_req),
  .in_ack         (in_ack),
  .out_req        (out_req),
  .out_ack        (out_ack),
  .result         (result),
  .expt           (expt),
  .a_full         (hs4_buffer_a_i.full),
  .b_full         (hs4_buffer_b_i.full),
  .b_in_ack       (buf_b_ack)
);

//--- verification/fdsu_pack_tb.sv
/*
  Testbench for the result packer. Items go in with four-phase req/ack and
  must come out in order. Downstream ack follows after random delays.
  Expected values come from the packing rules. Random stimulus uses seed 91906.
*/
`timescale 1ns/1ps

module fdsu_pack_tb;

  import fp_format_pkg::*;

  localparam int N_ITEMS = 46;

  logic        forever_cpuclk = 1'b0;
  logic        reset;
  logic        in_req;
  logic        in_ack;
  fp_fmt_t     fmt;
  logic        sign;
  logic [54:0] frac;
  logic [12:0] expnt;
  logic        nv;
  logic        dz;
  logic        of;
  logic        uf;
  logic        nx;
  logic        potnt_of;
  logic        potnt_uf;
  logic        of_rm_lfn;
  logic        result_zero;
  logic        result_qnan;
  logic        result_inf;
  logic        result_lfn;
  logic        result_nor;
  logic        out_req;
  logic        out_ack;
  logic [63:0] result;
  logic [4:0]  expt;

  // Expected {result, flags} with the oldest first
  logic [68:0] exp_q[$];
  integer      seed = 91906;
  logic        hold_ack = 1'b0;
  int          err_cnt = 0;
  int          errs_mark = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;

  fdsu_pack_top fdsu_pack_top_i (.*);

  always #4 forever_cpuclk = ~forever_cpuclk;

  function automatic int total_errors();
    return err_cnt + fdsu_pack_top_i.fdsu_pack_sva_i.fail_cnt;
  endfunction

  // Expected {result, flags} for the inputs now driven
  function automatic logic [68:0] expected_item();
    logic [1:0]  top;
    logic [12:0] e;
    logic [51:0] nf;
    logic        ofp;
    logic        ufp;
    logic        sg;
    int          ew;
    int          fw;
    logic [63:0] emax;
    logic [63:0] ev;
    logic [63:0] fv;
    logic [63:0] r;
    top = frac[54:53];
    ofp = potnt_of && (top != 2'b00) && result_nor;
    ufp = potnt_uf && (top == 2'b00) && result_nor;
    e   = (top == 2'b00) ? expnt - 13'd1 : (top == 2'b01) ? expnt : expnt + 13'd1;
    nf  = (top == 2'b00) ? frac[51:0] : (top == 2'b01) ? frac[52:1] : frac[53:2];
    ew  = (fmt == FMT_SINGLE) ? 8 : (fmt == FMT_HALF) ? 5 : 11;
    fw  = (fmt == FMT_SINGLE) ? 23 : (fmt == FMT_HALF) ? 10 : 52;
    emax = (64'd1 << ew) - 64'd1;
    sg   = sign;
    ev   = {51'd0, e} & emax;
    fv   = {12'd0, nf} >> (52 - fw);
    if (result_zero)
    begin
      ev = 64'd0;
      fv = 64'd0;
    end
    else if (result_qnan)
    begin
      sg = 1'b0;
      ev = emax;
      fv = 64'd1 << (fw - 1);
    end
    else if ((ofp && !of_rm_lfn) || result_inf)
    begin
      ev = emax;
      fv = 64'd0;
    end
    else if ((ofp && of_rm_lfn) || result_lfn)
    begin
      ev = emax - 64'd1;
      fv = (64'd1 << fw) - 64'd1;
    end
    r = ({63'd0, sg} << (ew + fw)) | (ev << fw) | fv;
    // NaN boxing above narrower formats
    if (fmt != FMT_DOUBLE)
      r = r | (~64'd0 << (1 + ew + fw));
    return {r, nv, dz, of || ofp, (uf || ufp) && nx, nx || of || ofp};
  endfunction

  // Random operands of the normal class without hints
  task automatic random_fields(input fp_fmt_t f);
    fmt        = f;
    sign       = 1'($random(seed));
    frac       = 55'({$random(seed), $random(seed)});
    expnt      = 13'($random(seed));
    {nv, dz, of, uf, nx} = 5'($random(seed));
    potnt_of   = 1'b0;
    potnt_uf   = 1'b0;
    of_rm_lfn  = 1'($random(seed));
    {result_zero, result_qnan, result_inf, result_lfn} = 4'b0000;
    result_nor = 1'b1;
  endtask

  task automatic wait_cycle();
    @(posedge forever_cpuclk);
    #1;
  endtask

  // Full four-phase cycle on the upstream side
  task automatic put_item();
    exp_q.push_back(expected_item());
    in_req = 1'b1;
    do wait_cycle(); while (!in_ack);
    in_req = 1'b0;
    do wait_cycle(); while (in_ack);
  endtask

  task automatic check_item();
    logic [68:0] want;
    assert (exp_q.size() != 0)
    else
    begin
      $display("Unexpected output item at %0t ns, nothing was sent", $time);
      err_cnt++;
    end
    if (exp_q.size() != 0)
    begin
      want = exp_q.pop_front();
      assert (result == want[68:5] && expt == want[4:0])
      else
      begin
        $display("[ERROR] %0t ns: result %h expt %b, expected %h %b",
                 $time, result, expt, want[68:5], want[4:0]);
        err_cnt++;
      end
    end
  endtask

  task automatic finish_test(input string name);
    while (exp_q.size() != 0 || out_req || out_ack)
      wait_cycle();
    if (total_errors() == errs_mark)
    begin
      tests_ok++;
      $display("Test %s: PASS", name);
    end
    else
    begin
      tests_bad++;
      $display("Test %s: FAIL", name);
    end
    errs_mark = total_errors();
  endtask

  // Downstream side checks each item as out_req rises
  initial
  begin
    logic [1:0] gap;
    out_ack = 1'b0;
    forever
    begin
      do wait_cycle(); while (!out_req);
      check_item();
      gap = 2'($random(seed));
      repeat (gap) wait_cycle();
      while (hold_ack)
        wait_cycle();
      out_ack = 1'b1;
      do wait_cycle(); while (out_req);
      out_ack = 1'b0;
    end
  end

  initial
  begin
    repeat (N_ITEMS * 40) @(posedge forever_cpuclk);
    $display("Timeout: handshake stalled, run did not end in %0d cycles", N_ITEMS * 40);
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    reset  = 1'b1;
    in_req = 1'b0;
    random_fields(FMT_DOUBLE);
    repeat (8) @(posedge forever_cpuclk);
    #1 reset = 1'b0;
    assert (!in_ack && !out_req)
    else
    begin
      $display("Handshake outputs active after reset at %0t ns", $time);
      err_cnt++;
    end

    for (int f = 0; f < 3; f++)
    begin
      for (int t = 0; t < 3; t++)
      begin
        random_fields(fp_fmt_t'(2'(f)));
        frac[54:53] = (t == 2) ? {1'b1, frac[53]} : 2'(t);
        put_item();
      end
    end
    finish_test("normal results");

    for (int f = 0; f < 3; f++)
    begin
      for (int m = 0; m < 2; m++)
      begin
        random_fields(fp_fmt_t'(2'(f)));
        potnt_of  = 1'b1;
        frac[53]  = 1'b1;
        of_rm_lfn = 1'(m);
        put_item();
      end
    end
    random_fields(FMT_SINGLE);
    result_nor = 1'b0;
    result_inf = 1'b1;
    put_item();
    random_fields(FMT_HALF);
    result_nor = 1'b0;
    result_lfn = 1'b1;
    put_item();
    finish_test("late overflow");

    for (int f = 0; f < 3; f++)
    begin
      random_fields(fp_fmt_t'(2'(f)));
      {result_zero, result_nor} = 2'b10;
      put_item();
      random_fields(fp_fmt_t'(2'(f)));
      {result_qnan, result_nor} = 2'b10;
      put_item();
    end
    random_fields(FMT_DOUBLE);
    {result_zero, result_qnan, result_inf} = 3'b111;
    put_item();
    random_fields(FMT_SINGLE);
    {result_qnan, result_inf, result_lfn} = 3'b111;
    put_item();
    // Late overflow to infinity beats the lfn hint
    random_fields(FMT_HALF);
    {potnt_of, frac[53], of_rm_lfn, result_lfn} = 4'b1101;
    put_item();
    finish_test("zero, NaN and priority");

    random_fields(FMT_DOUBLE);
    {potnt_uf, frac[54:53], uf, nx} = 5'b10001;
    put_item();
    random_fields(FMT_SINGLE);
    {potnt_uf, frac[54:53], uf, nx} = 5'b10000;
    put_item();
    random_fields(FMT_HALF);
    {uf, nx} = 2'b10;
    put_item();
    random_fields(FMT_DOUBLE);
    {potnt_of, frac[54:53], of, nx} = 5'b10100;
    put_item();
    for (int i = 0; i < 8; i++)
    begin
      random_fields(fp_fmt_t'(2'(i % 3)));
      potnt_of = 1'($random(seed));
      potnt_uf = 1'($random(seed));
      put_item();
    end
    finish_test("flag correction");

    // Two items held under back-pressure while the third waits
    hold_ack = 1'b1;
    random_fields(FMT_DOUBLE);
    put_item();
    random_fields(FMT_SINGLE);
    put_item();
    random_fields(FMT_HALF);
    fork
      put_item();
      begin
        repeat (8) wait_cycle();
        assert (in_req && !in_ack && out_req)
        else
        begin
          $display("Back-pressure broken at %0t ns, third item taken or output lost", $time);
          err_cnt++;
        end
        hold_ack = 1'b0;
      end
    join
    for (int i = 0; i < 5; i++)
    begin
      random_fields(fp_fmt_t'(2'(i % 3)));
      put_item();
    end
    finish_test("handshake and order");

    $display("Tests passed: %0d, failed: %0d", tests_ok, tests_bad);
    if (tests_bad == 0 && total_errors() == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- fdsu_pack_top.f
verilog/fp_format_pkg.sv
verilog/pack_pipe_pkg.sv
verilog/fdsu_expnt_adjust.sv
verilog/hs4_buffer.sv
verilog/fdsu_result_pack.sv
verilog/fdsu_pack_top.sv
verification/fdsu_pack_sva.sv
verification/fdsu_pack_tb.sv

//--- Makefile
# Verilator simulation of the divide/square-root result packer

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation with Verilator"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module fdsu_pack_tb \
		-f fdsu_pack_top.f -o fdsu_pack_sim
	@out=$$(./obj_dir/fdsu_pack_sim +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
